// ==== hw/dcache_pkg.sv ====
/*
  Shared sizes, request types and memory message types for the
  multi-lane data cache array. Modules import it inside their bodies
  and name its types by scope in their port lists.
*/
package dcache_pkg;

   // Array shape
   localparam int NUM_LANES = 2;
   localparam int LANE_ID_W = 1;

   // Dword addressing, one dword per line
   localparam int ADDR_W  = 12;
   localparam int DATA_W  = 64;
   localparam int SETS    = 16;
   localparam int INDEX_W = 4;
   localparam int TAG_W   = ADDR_W - INDEX_W;

   // Replay FIFO depth; pointers carry one extra wrap bit
   localparam int ROLLY_ELS   = 8;
   localparam int ROLLY_PTR_W = 3;

   typedef logic [LANE_ID_W-1:0] lane_id_t;
   typedef logic [ADDR_W-1:0]    addr_t;
   typedef logic [DATA_W-1:0]    data_t;
   typedef logic [INDEX_W-1:0]   index_t;
   typedef logic [TAG_W-1:0]     tag_t;

   typedef enum logic
   {
      OP_LOAD  = 1'b0,
      OP_STORE = 1'b1
   } dcache_op_e;

   // Lane request as held in the replay FIFO, 77 bits
   typedef struct packed
   {
      dcache_op_e op;
      addr_t      addr;
      data_t      data;
   } dcache_req_t;

   typedef enum logic
   {
      MEM_RD = 1'b0,
      MEM_WR = 1'b1
   } mem_op_e;

   // Memory command or response, 78 bits
   // lane names the requester and is echoed back in the response
   typedef struct packed
   {
      mem_op_e  op;
      lane_id_t lane;
      addr_t    addr;
      data_t    data;
   } mem_msg_t;

endpackage

// ==== hw/rollback_fifo.sv ====
/*
  Replay FIFO for one cache lane. Entries stay stored after they are
  read and only leave on commit. A rollback moves the read pointer back
  to the oldest uncommitted entry so the pipeline replays from there.
*/
`timescale 1ns/1ns

module rollback_fifo
(
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  logic                    enq_v_i,
   input  dcache_pkg::dcache_req_t enq_i,
   output logic                    ready_o,
   output logic                    head_v_o,
   output dcache_pkg::dcache_req_t head_o,
   input  logic                    read_i,
   input  logic                    commit_i,
   input  logic                    rollback_i
);

   import dcache_pkg::*;

   dcache_req_t mem_r [ROLLY_ELS];

   logic [ROLLY_PTR_W:0] wr_ptr_r;
   logic [ROLLY_PTR_W:0] rd_ptr_r;
   logic [ROLLY_PTR_W:0] cm_ptr_r;
   logic [ROLLY_PTR_W:0] cm_ptr_next;
   logic                 enq;

   // Full once the writer laps the commit pointer
   assign ready_o = ~((wr_ptr_r[ROLLY_PTR_W-1:0] == cm_ptr_r[ROLLY_PTR_W-1:0])
                      && (wr_ptr_r[ROLLY_PTR_W] != cm_ptr_r[ROLLY_PTR_W]));

   assign head_v_o = (rd_ptr_r != wr_ptr_r);
   assign head_o   = mem_r[rd_ptr_r[ROLLY_PTR_W-1:0]];

   assign enq         = enq_v_i & ready_o;
   assign cm_ptr_next = commit_i ? cm_ptr_r + 1'b1 : cm_ptr_r;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         cm_ptr_r <= '0;
      end
      else
      begin
         if (enq)
         begin
            wr_ptr_r <= wr_ptr_r + 1'b1;
         end
         // Rewind wins over a read in the same cycle
         if (rollback_i)
         begin
            rd_ptr_r <= cm_ptr_next;
         end
         else if (read_i & head_v_o)
         begin
            rd_ptr_r <= rd_ptr_r + 1'b1;
         end
         cm_ptr_r <= cm_ptr_next;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (enq)
      begin
         mem_r[wr_ptr_r[ROLLY_PTR_W-1:0]] <= enq_i;
      end
   end

endmodule

// ==== hw/dcache_lane.sv ====
/*
  One direct-mapped, write-through cache lane. Requests pass through a
  replay FIFO into a two-stage pipeline: stage 1 looks up the line,
  stage 2 returns a result or poisons and rewinds the FIFO. A single
  miss slot holds the one memory operation the lane may have in flight.
*/
`timescale 1ns/1ns

module dcache_lane
(
   input  logic                      clk_i,
   input  logic                      rst_i,
   input  dcache_pkg::lane_id_t      lane_id_i,
   input  logic                      req_v_i,
   input  dcache_pkg::dcache_req_t   req_i,
   output logic                      ready_o,
   output logic [dcache_pkg::DATA_W-1:0] data_o,
   output logic                      v_o,
   output logic                      cmd_v_o,
   output dcache_pkg::mem_msg_t      cmd_o,
   input  logic                      cmd_grant_i,
   input  logic                      fill_v_i,
   input  logic                      ack_v_i,
   input  logic [dcache_pkg::DATA_W-1:0] resp_data_i
);

   import dcache_pkg::*;

   dcache_req_t head;
   dcache_req_t s1_req;
   dcache_req_t s2_req;
   logic        head_v;
   logic        issue;
   logic        s1_v;
   logic        s2_v;
   logic        s2_hit;
   data_t       s2_data;
   logic        s2_store;
   logic        poison;
   logic        send_cmd;

   logic [SETS-1:0] valid_r;
   tag_t            tag_mem [SETS];
   data_t           data_mem [SETS];

   logic   slot_busy;
   addr_t  slot_addr;

   logic   arr_we;
   index_t arr_idx;
   tag_t   arr_tag;
   data_t  arr_data;
   index_t s1_idx;
   tag_t   s1_tag;
   logic   s1_hit;
   data_t  s1_data;

   rollback_fifo u_fifo
   (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .enq_v_i    (req_v_i),
      .enq_i      (req_i),
      .ready_o    (ready_o),
      .head_v_o   (head_v),
      .head_o     (head),
      .read_i     (issue),
      .commit_i   (v_o),
      .rollback_i (poison)
   );

   // No issue while the read pointer is being rewound
   assign issue = head_v & ~poison;

   assign s2_store = (s2_req.op == OP_STORE);
   // Stores need the slot for their MEM_WR, loads need a hit
   assign v_o      = s2_v & (s2_store ? ~slot_busy : s2_hit);
   assign poison   = s2_v & ~v_o;
   assign data_o   = s2_store ? '0 : s2_data;
   assign send_cmd = s2_v & ~slot_busy & (s2_store | ~s2_hit);

   // Single array write port; a fill and a completing store never coincide
   always_comb
   begin
      arr_we   = 1'b0;
      arr_idx  = s2_req.addr[INDEX_W-1:0];
      arr_tag  = s2_req.addr[ADDR_W-1:INDEX_W];
      arr_data = s2_req.data;
      if (fill_v_i)
      begin
         arr_we   = 1'b1;
         arr_idx  = slot_addr[INDEX_W-1:0];
         arr_tag  = slot_addr[ADDR_W-1:INDEX_W];
         arr_data = resp_data_i;
      end
      else if (s2_v & s2_store & s2_hit & ~slot_busy)
      begin
         arr_we = 1'b1;
      end
   end

   // Stage 1 lookup, bypassing a write to the same line
   always_comb
   begin
      s1_idx = s1_req.addr[INDEX_W-1:0];
      s1_tag = s1_req.addr[ADDR_W-1:INDEX_W];
      if (arr_we && (arr_idx == s1_idx))
      begin
         s1_hit  = (arr_tag == s1_tag);
         s1_data = arr_data;
      end
      else
      begin
         s1_hit  = valid_r[s1_idx] && (tag_mem[s1_idx] == s1_tag);
         s1_data = data_mem[s1_idx];
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         s1_v      <= 1'b0;
         s2_v      <= 1'b0;
         valid_r   <= '0;
         slot_busy <= 1'b0;
         cmd_v_o   <= 1'b0;
      end
      else
      begin
         s1_v <= issue;
         s2_v <= s1_v & ~poison;
         if (arr_we)
         begin
            valid_r[arr_idx] <= 1'b1;
         end
         if (send_cmd)
         begin
            slot_busy <= 1'b1;
         end
         else if (fill_v_i | ack_v_i)
         begin
            slot_busy <= 1'b0;
         end
         if (send_cmd)
         begin
            cmd_v_o <= 1'b1;
         end
         else if (cmd_grant_i)
         begin
            cmd_v_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      s1_req  <= head;
      s2_req  <= s1_req;
      s2_hit  <= s1_hit;
      s2_data <= s1_data;
      if (arr_we)
      begin
         tag_mem[arr_idx]  <= arr_tag;
         data_mem[arr_idx] <= arr_data;
      end
      if (send_cmd)
      begin
         slot_addr  <= s2_req.addr;
         cmd_o.op   <= s2_store ? MEM_WR : MEM_RD;
         cmd_o.lane <= lane_id_i;
         cmd_o.addr <= s2_req.addr;
         cmd_o.data <= s2_req.data;
      end
   end

endmodule

// ==== hw/mem_cmd_arbiter.sv ====
/*
  Round-robin arbiter from the lane command slots to the single memory
  command port. The chosen command sits in an output register until
  memory takes it; the winning lane gets a one-cycle grant.
*/
`timescale 1ns/1ns

module mem_cmd_arbiter
(
   input  logic                                   clk_i,
   input  logic                                   rst_i,
   input  logic [dcache_pkg::NUM_LANES-1:0]       cmd_v_i,
   input  dcache_pkg::mem_msg_t [dcache_pkg::NUM_LANES-1:0] cmd_i,
   output logic [dcache_pkg::NUM_LANES-1:0]       cmd_grant_o,
   output logic                                   mem_cmd_v_o,
   output dcache_pkg::mem_msg_t                   mem_cmd_o,
   input  logic                                   mem_cmd_ready_i
);

   import dcache_pkg::*;

   lane_id_t last_r;
   lane_id_t pick;
   logic     pick_v;
   logic     load_en;

   assign load_en = ~mem_cmd_v_o | mem_cmd_ready_i;

   // Nearest requester after the last winner, checked last so it wins
   always_comb
   begin
      int idx;
      pick_v = 1'b0;
      pick   = last_r;
      for (int k = NUM_LANES; k >= 1; k--)
      begin
         idx = (int'(last_r) + k) % NUM_LANES;
         if (cmd_v_i[idx])
         begin
            pick_v = 1'b1;
            pick   = lane_id_t'(idx);
         end
      end
   end

   always_comb
   begin
      cmd_grant_o = '0;
      if (load_en & pick_v)
      begin
         cmd_grant_o[pick] = 1'b1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         mem_cmd_v_o <= 1'b0;
         last_r      <= '0;
      end
      else if (load_en)
      begin
         mem_cmd_v_o <= pick_v;
         if (pick_v)
         begin
            last_r <= pick;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (load_en & pick_v)
      begin
         mem_cmd_o <= cmd_i[pick];
      end
   end

endmodule

// ==== hw/mem_resp_router.sv ====
/*
  Takes every memory response at once and, one cycle later, steers it
  to the lane named in it: a read becomes a fill, a write an ack.
*/
`timescale 1ns/1ns

module mem_resp_router
(
   input  logic                                  clk_i,
   input  logic                                  rst_i,
   input  logic                                  mem_resp_v_i,
   input  dcache_pkg::mem_msg_t                  mem_resp_i,
   output logic                                  mem_resp_yumi_o,
   output logic [dcache_pkg::NUM_LANES-1:0]      fill_v_o,
   output logic [dcache_pkg::NUM_LANES-1:0]      ack_v_o,
   output logic [dcache_pkg::DATA_W-1:0]         resp_data_o
);

   import dcache_pkg::*;

   // Always room, one response per cycle
   assign mem_resp_yumi_o = mem_resp_v_i;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         fill_v_o <= '0;
         ack_v_o  <= '0;
      end
      else
      begin
         fill_v_o <= '0;
         ack_v_o  <= '0;
         if (mem_resp_v_i)
         begin
            if (mem_resp_i.op == MEM_RD)
            begin
               fill_v_o[mem_resp_i.lane] <= 1'b1;
            end
            else
            begin
               ack_v_o[mem_resp_i.lane] <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      resp_data_o <= mem_resp_i.data;
   end

endmodule

// ==== hw/dcache_array_top.sv ====
/*
  Top level of the multi-lane data cache. Each lane has its own request
  and result port; all lanes share one memory command port through the
  arbiter and one memory response port through the router.
*/
`timescale 1ns/1ns

module dcache_array_top
(
   input  logic                                              clk_i,
   input  logic                                              rst_i,
   input  logic [dcache_pkg::NUM_LANES-1:0]                  req_v_i,
   input  dcache_pkg::dcache_req_t [dcache_pkg::NUM_LANES-1:0] req_i,
   output logic [dcache_pkg::NUM_LANES-1:0]                  ready_o,
   output logic [dcache_pkg::NUM_LANES-1:0][dcache_pkg::DATA_W-1:0] data_o,
   output logic [dcache_pkg::NUM_LANES-1:0]                  v_o,
   output logic                                              mem_cmd_v_o,
   output dcache_pkg::mem_msg_t                              mem_cmd_o,
   input  logic                                              mem_cmd_ready_i,
   input  logic                                              mem_resp_v_i,
   input  dcache_pkg::mem_msg_t                              mem_resp_i,
   output logic                                              mem_resp_yumi_o
);

   import dcache_pkg::*;

   logic [NUM_LANES-1:0]     cmd_v;
   mem_msg_t [NUM_LANES-1:0] cmd;
   logic [NUM_LANES-1:0]     cmd_grant;
   logic [NUM_LANES-1:0]     fill_v;
   logic [NUM_LANES-1:0]     ack_v;
   data_t                    resp_data;

   mem_resp_router u_router
   (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .mem_resp_v_i    (mem_resp_v_i),
      .mem_resp_i      (mem_resp_i),
      .mem_resp_yumi_o (mem_resp_yumi_o),
      .fill_v_o        (fill_v),
      .ack_v_o         (ack_v),
      .resp_data_o     (resp_data)
   );

   for (genvar i = 0; i < NUM_LANES; i++)
   begin : g_lane
      dcache_lane u_lane
      (
         .clk_i       (clk_i),
         .rst_i       (rst_i),
         .lane_id_i   (lane_id_t'(i)),
         .req_v_i     (req_v_i[i]),
         .req_i       (req_i[i]),
         .ready_o     (ready_o[i]),
         .data_o      (data_o[i]),
         .v_o         (v_o[i]),
         .cmd_v_o     (cmd_v[i]),
         .cmd_o       (cmd[i]),
         .cmd_grant_i (cmd_grant[i]),
         .fill_v_i    (fill_v[i]),
         .ack_v_i     (ack_v[i]),
         .resp_data_i (resp_data)
      );
   end

   mem_cmd_arbiter u_arbiter
   (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .cmd_v_i         (cmd_v),
      .cmd_i           (cmd),
      .cmd_grant_o     (cmd_grant),
      .mem_cmd_v_o     (mem_cmd_v_o),
      .mem_cmd_o       (mem_cmd_o),
      .mem_cmd_ready_i (mem_cmd_ready_i)
   );

endmodule

// ==== dv/tb_clk_gen.sv ====
/*
  Testbench clock and reset source. Drives a 10 ns clock and holds a
  synchronous active-high reset for the first four rising edges.
*/
`timescale 1ns/1ns

module tb_clk_gen
(
   output logic clk_o,
   output logic rst_o
);

   localparam int HALF_PERIOD_NS = 5;
   localparam int RESET_CYCLES   = 4;

   initial
   begin
      clk_o = 1'b0;
      forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
   end

   initial
   begin
      rst_o <= 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      rst_o <= 1'b0;
   end

endmodule

// ==== dv/tb_dcache_array.sv ====
/*
  Testbench for the multi-lane data cache array. A request table is
  applied to both lanes at once, a memory model answers commands with
  random delays and stalls, and a per-lane reference model checks every
  result. The second part of the table runs with memory held stalled.
*/
`timescale 1ns/1ns

module tb_dcache_array;

   import dcache_pkg::*;

   localparam int TABLE_LEN        = 28;
   localparam int PHASE1_LEN       = 16;
   localparam int CLK_PERIOD_NS    = 10;
   localparam int CYCLES_PER_ENTRY = 200;
   localparam int WATCHDOG_NS      = TABLE_LEN * CYCLES_PER_ENTRY * CLK_PERIOD_NS;
   localparam int FULL_WAIT_LIMIT  = 300;
   localparam logic [31:0] LFSR_SEED = 32'h4938_ee30;

   typedef struct packed
   {
      logic       lane;
      dcache_op_e op;
      addr_t      addr;
      data_t      data;
   } stim_t;

   typedef struct packed
   {
      addr_t addr;
      data_t data;
   } wr_t;

   logic                           clk;
   logic                           rst;
   logic [NUM_LANES-1:0]           req_v;
   dcache_req_t [NUM_LANES-1:0]    req;
   logic [NUM_LANES-1:0]           ready_o;
   logic [NUM_LANES-1:0][DATA_W-1:0] data_o;
   logic [NUM_LANES-1:0]           v_o;
   logic                           mem_cmd_v_o;
   mem_msg_t                       mem_cmd_o;
   logic                           mem_cmd_ready_i;
   logic                           mem_resp_v_i;
   mem_msg_t                       mem_resp_i;
   logic                           mem_resp_yumi_o;

   stim_t       stim_table [TABLE_LEN];
   int          stim_count;
   data_t       mem_model [1 << ADDR_W];
   data_t       ref_mem [1 << ADDR_W];
   data_t       exp_q [NUM_LANES][$];
   wr_t         wr_q [NUM_LANES][$];
   mem_msg_t    resp_q [$];
   int          due_q [$];
   logic [31:0] lfsr_state;
   logic        hold_cmd_ready;
   int          pending;
   int          result_count;
   int          check_count;
   int          mismatch_count;
   int          other_errors;

   tb_clk_gen u_clk_gen
   (
      .clk_o (clk),
      .rst_o (rst)
   );

   dcache_array_top i_dcache_array_top
   (
      .clk_i           (clk),
      .rst_i           (rst),
      .req_v_i         (req_v),
      .req_i           (req),
      .ready_o         (ready_o),
      .data_o          (data_o),
      .v_o             (v_o),
      .mem_cmd_v_o     (mem_cmd_v_o),
      .mem_cmd_o       (mem_cmd_o),
      .mem_cmd_ready_i (mem_cmd_ready_i),
      .mem_resp_v_i    (mem_resp_v_i),
      .mem_resp_i      (mem_resp_i),
      .mem_resp_yumi_o (mem_resp_yumi_o)
   );

   // Memory contents before any store
   function automatic data_t init_pattern(input addr_t a);
      return {20'hca5e1, a, 20'h7b3d0, ~a};
   endfunction

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   task automatic draw_bits(input int n, output logic [7:0] val);
      val = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_step(lfsr_state);
         val = {val[6:0], lfsr_state[0]};
      end
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      check_count++;
      if (got !== exp)
      begin
         $display("ERR %s: got %h, expected %h", name, got, exp);
         mismatch_count++;
      end
   endtask

   task automatic add_entry(input int lane, input dcache_op_e op, input addr_t addr,
                            input data_t data);
      stim_table[stim_count].lane = lane[0];
      stim_table[stim_count].op   = op;
      stim_table[stim_count].addr = addr;
      stim_table[stim_count].data = data;
      stim_count++;
   endtask

   // Lane 0 uses addresses below 12'h800, lane 1 the rest
   task automatic load_table();
      stim_count = 0;
      add_entry(0, OP_LOAD,  12'h010, '0);
      add_entry(1, OP_LOAD,  12'h810, '0);
      add_entry(0, OP_LOAD,  12'h010, '0);
      add_entry(1, OP_LOAD,  12'h810, '0);
      add_entry(0, OP_STORE, 12'h010, 64'h1111_2222_3333_4444);
      add_entry(0, OP_LOAD,  12'h010, '0);
      add_entry(1, OP_STORE, 12'h823, 64'h5555_6666_7777_8888);
      add_entry(1, OP_LOAD,  12'h823, '0);
      // Same index as 12'h010, so the next load refetches from memory
      add_entry(0, OP_LOAD,  12'h020, '0);
      add_entry(0, OP_LOAD,  12'h010, '0);
      add_entry(1, OP_STORE, 12'h810, 64'h9999_aaaa_bbbb_cccc);
      add_entry(1, OP_LOAD,  12'h810, '0);
      add_entry(0, OP_STORE, 12'h135, 64'hdead_beef_0123_4567);
      add_entry(1, OP_LOAD,  12'h9a7, '0);
      add_entry(0, OP_LOAD,  12'h135, '0);
      add_entry(1, OP_LOAD,  12'h823, '0);
      // Stalled part with enough lane 0 requests to fill its FIFO
      add_entry(0, OP_LOAD,  12'h300, '0);
      add_entry(0, OP_LOAD,  12'h311, '0);
      add_entry(1, OP_LOAD,  12'h900, '0);
      add_entry(0, OP_LOAD,  12'h322, '0);
      add_entry(0, OP_STORE, 12'h333, 64'h0f0f_1e1e_2d2d_3c3c);
      add_entry(1, OP_STORE, 12'h911, 64'h4b4b_5a5a_6969_7878);
      add_entry(0, OP_LOAD,  12'h333, '0);
      add_entry(0, OP_LOAD,  12'h344, '0);
      add_entry(0, OP_LOAD,  12'h355, '0);
      add_entry(0, OP_LOAD,  12'h366, '0);
      add_entry(0, OP_LOAD,  12'h377, '0);
      add_entry(0, OP_LOAD,  12'h300, '0);
   endtask

   // Reference model updated in request order per lane
   task automatic record_expected(input int i);
      int  lane;
      wr_t w;
      lane = int'(stim_table[i].lane);
      if (stim_table[i].op == OP_STORE)
      begin
         ref_mem[stim_table[i].addr] = stim_table[i].data;
         w.addr = stim_table[i].addr;
         w.data = stim_table[i].data;
         wr_q[lane].push_back(w);
         exp_q[lane].push_back('0);
      end
      else
      begin
         exp_q[lane].push_back(ref_mem[stim_table[i].addr]);
      end
      pending++;
   endtask

   // Both lanes walk the table together, each taking its own entries
   task automatic run_phase(input int first, input int last);
      int          ptr [NUM_LANES];
      int          cur [NUM_LANES];
      logic        busy [NUM_LANES];
      logic        any_busy;
      dcache_req_t r;
      for (int l = 0; l < NUM_LANES; l++)
      begin
         ptr[l]  = first;
         cur[l]  = first;
         busy[l] = 1'b0;
      end
      any_busy = 1'b1;
      while (any_busy)
      begin
         @(posedge clk);
         any_busy = 1'b0;
         for (int l = 0; l < NUM_LANES; l++)
         begin
            if (!busy[l])
            begin
               while (ptr[l] < last && int'(stim_table[ptr[l]].lane) != l)
               begin
                  ptr[l]++;
               end
               if (ptr[l] < last)
               begin
                  cur[l]  = ptr[l];
                  ptr[l]++;
                  busy[l] = 1'b1;
                  r.op    = stim_table[cur[l]].op;
                  r.addr  = stim_table[cur[l]].addr;
                  r.data  = stim_table[cur[l]].data;
                  req_v[l] <= 1'b1;
                  req[l]   <= r;
               end
               else
               begin
                  req_v[l] <= 1'b0;
               end
            end
            any_busy = any_busy | busy[l];
         end
         if (any_busy)
         begin
            @(negedge clk);
            for (int l = 0; l < NUM_LANES; l++)
            begin
               if (busy[l] && ready_o[l])
               begin
                  record_expected(cur[l]);
                  busy[l] = 1'b0;
               end
            end
         end
      end
   endtask

   task automatic wait_idle();
      while (pending != 0)
      begin
         @(negedge clk);
      end
   endtask

   // Holds memory stalled until lane 0 back-pressures, then releases it
   task automatic watch_full();
      int waited;
      waited = 0;
      while (ready_o[0] && waited < FULL_WAIT_LIMIT)
      begin
         @(negedge clk);
         waited++;
      end
      if (ready_o[0])
      begin
         $display("lane 0 kept ready_o high while memory was stalled");
         other_errors++;
      end
      repeat (20) @(negedge clk);
      hold_cmd_ready = 1'b0;
   endtask

   task automatic take_command(input mem_msg_t cmd, input int now);
      mem_msg_t   rsp;
      wr_t        w;
      logic [7:0] delay;
      int         due;
      check_value("mem_cmd_o.lane", 64'(cmd.lane), 64'(cmd.addr[ADDR_W-1]));
      rsp = cmd;
      if (cmd.op == MEM_WR)
      begin
         if (wr_q[cmd.lane].size() == 0)
         begin
            $display("memory got a write from lane %0d with no store pending", cmd.lane);
            other_errors++;
         end
         else
         begin
            w = wr_q[cmd.lane].pop_front();
            check_value("mem_cmd_o.addr", 64'(cmd.addr), 64'(w.addr));
            check_value("mem_cmd_o.data", cmd.data, w.data);
         end
         mem_model[cmd.addr] = cmd.data;
         rsp.data = '0;
      end
      else
      begin
         rsp.data = mem_model[cmd.addr];
      end
      draw_bits(3, delay);
      due = now + int'(delay) + 1;
      if (due_q.size() > 0 && due <= due_q[$])
      begin
         due = due_q[$] + 1;
      end
      resp_q.push_back(rsp);
      due_q.push_back(due);
   endtask

   // Memory model samples on the falling edge and drives on the rising edge
   initial
   begin
      logic [7:0] bits;
      int         mem_cycle;
      mem_cycle = 0;
      mem_cmd_ready_i <= 1'b0;
      mem_resp_v_i    <= 1'b0;
      mem_resp_i      <= '0;
      forever
      begin
         @(negedge clk);
         if (!rst)
         begin
            if (mem_cmd_v_o && mem_cmd_ready_i)
            begin
               take_command(mem_cmd_o, mem_cycle);
            end
            if (mem_resp_v_i && !mem_resp_yumi_o)
            begin
               $display("memory response was not consumed");
               other_errors++;
            end
         end
         @(posedge clk);
         mem_cycle++;
         draw_bits(2, bits);
         mem_cmd_ready_i <= ~hold_cmd_ready & (bits != 8'd0);
         if (due_q.size() > 0 && due_q[0] <= mem_cycle)
         begin
            mem_resp_v_i <= 1'b1;
            mem_resp_i   <= resp_q.pop_front();
            void'(due_q.pop_front());
         end
         else
         begin
            mem_resp_v_i <= 1'b0;
         end
      end
   end

   // Result monitor
   initial
   begin
      data_t exp;
      forever
      begin
         @(negedge clk);
         for (int l = 0; l < NUM_LANES; l++)
         begin
            if (!rst && v_o[l])
            begin
               result_count++;
               if (exp_q[l].size() == 0)
               begin
                  $display("lane %0d gave a result with no request outstanding", l);
                  other_errors++;
               end
               else
               begin
                  exp = exp_q[l].pop_front();
                  check_value($sformatf("data_o[%0d]", l), data_o[l], exp);
                  pending--;
               end
            end
         end
      end
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("watchdog expired before all requests completed");
      $display(">>> FAIL");
      $finish;
   end

   initial
   begin
      req_v          <= '0;
      req            <= '0;
      lfsr_state     = LFSR_SEED;
      hold_cmd_ready = 1'b0;
      pending        = 0;
      result_count   = 0;
      check_count    = 0;
      mismatch_count = 0;
      other_errors   = 0;
      for (int a = 0; a < (1 << ADDR_W); a++)
      begin
         mem_model[a] = init_pattern(addr_t'(a));
         ref_mem[a]   = init_pattern(addr_t'(a));
      end
      load_table();

      @(negedge clk);
      while (rst)
      begin
         @(negedge clk);
      end
      repeat (3)
      begin
         @(negedge clk);
         check_value("v_o", 64'(v_o), 64'd0);
         check_value("mem_cmd_v_o", 64'(mem_cmd_v_o), 64'd0);
      end

      run_phase(0, PHASE1_LEN);
      wait_idle();

      hold_cmd_ready = 1'b1;
      fork
         run_phase(PHASE1_LEN, TABLE_LEN);
         watch_full();
      join
      wait_idle();

      // Room for any stray extra result
      repeat (30) @(negedge clk);
      check_value("result count", 64'(result_count), 64'(TABLE_LEN));
      for (int l = 0; l < NUM_LANES; l++)
      begin
         check_value($sformatf("writes left on lane %0d", l), 64'(wr_q[l].size()), 64'd0);
      end

      $display("checks %0d, value mismatches %0d, other errors %0d",
               check_count, mismatch_count, other_errors);
      if (mismatch_count == 0 && other_errors == 0)
      begin
         $display(">>> PASS");
      end
      else
      begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// ==== compile.f ====
hw/dcache_pkg.sv
hw/rollback_fifo.sv
hw/dcache_lane.sv
hw/mem_cmd_arbiter.sv
hw/mem_resp_router.sv
hw/dcache_array_top.sv
dv/tb_clk_gen.sv
dv/tb_dcache_array.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_dcache_array
FILELIST  := compile.f
BUILD_DIR := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@grep -q ">>> PASS" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
